// File: files.f
verilog/core_pkg.sv
verilog/stage_if.sv
verilog/fetch.sv
verilog/regfile.sv
verilog/decode.sv
verilog/execute.sv
verilog/core_top.sv
tests/tb_clock.sv
tests/core_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only -Wall --timing
TOP      = core_tb
RTL_TOP  = core_top
FILELIST = files.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/core_tb.sv
// three-stage core testbench
`timescale 1ns/1ns
`default_nettype none

module core_tb
    import core_pkg::*;
#(
    parameter int CODE_AW = 8
) ();

    localparam int          PERIOD       = 10;
    localparam int          RESET_CYCLES = 16;
    localparam int          DIRECTED_LEN = 15;
    localparam int          RANDOM_LEN   = 200;
    localparam int          PROG_LEN     = DIRECTED_LEN + RANDOM_LEN + 1;
    localparam int          CHAIN_LEN    = 9;       // dependent commits, one per cycle.
    localparam int          WATCHDOG     = 20 * PROG_LEN + RESET_CYCLES;
    localparam logic [31:0] SEED         = 32'hca60005c;

    logic               clk;
    logic               rst_n;
    logic [CODE_AW-1:0] code_addr;
    word_t              code_data;
    logic               commit_valid;
    reg_addr_t          commit_rd;
    word_t              commit_data;
    logic               commit_ready;
    logic               illegal;

    word_t              code_mem [2**CODE_AW];  // code port memory.
    reg_addr_t          exp_rd [$];             // expected commits in program order.
    word_t              exp_data [$];
    int                 directed_commits;
    int                 commits_seen;
    int                 edges;                  // edges since reset release.
    int                 first_edge;
    int                 last_edge;
    logic               stall_seen;
    logic [CODE_AW-1:0] stall_addr;
    logic               prog_ready;

    tb_clock #(
        .PERIOD(PERIOD),
        .RESET_CYCLES(RESET_CYCLES)
    ) clock_inst (
        .clk,
        .rst_n
    );

    core_top #(
        .CODE_AW(CODE_AW)
    ) core_top_inst (
        .clk,
        .rst_n,
        .code_addr,
        .code_data,
        .commit_valid,
        .commit_rd,
        .commit_data,
        .commit_ready,
        .illegal
    );

    assign code_data = code_mem[code_addr];     // same-cycle code read.

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic word_t encode(op_t op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                                     logic [15:0] imm);
        return {op, rd, rs1, rs2, 3'b000, imm};
    endfunction

    task automatic load_program();
        word_t inst;
        for (int i = 0; i < 2**CODE_AW; i++)
            code_mem[i] = {4'h0, 28'(i)};       // NOP words tagged with their address.
        code_mem[0]  = encode(ADDI, 3'd1, 3'd0, 3'd0, 16'h0123);
        code_mem[1]  = encode(ADD,  3'd2, 3'd1, 3'd1, 16'h0000);
        code_mem[2]  = encode(SUB,  3'd3, 3'd2, 3'd1, 16'h0000);
        code_mem[3]  = encode(AND,  3'd4, 3'd3, 3'd2, 16'h0000);
        code_mem[4]  = encode(OR,   3'd5, 3'd4, 3'd0, 16'h0000);
        code_mem[5]  = encode(XOR,  3'd6, 3'd5, 3'd2, 16'h0000);
        code_mem[6]  = encode(LUI,  3'd7, 3'd0, 3'd0, 16'hbeef);
        code_mem[7]  = encode(ADD,  3'd1, 3'd7, 3'd6, 16'h0000);
        code_mem[8]  = encode(ADDI, 3'd2, 3'd1, 3'd0, 16'hffff);  // minus one.
        code_mem[9]  = encode(NOP,  3'd3, 3'd1, 3'd2, 16'h5555);
        code_mem[10] = encode(NOP,  3'd0, 3'd0, 3'd0, 16'h0000);
        code_mem[11] = encode(ADDI, 3'd0, 3'd1, 3'd0, 16'h7777);  // write to r0.
        code_mem[12] = encode(ADD,  3'd3, 3'd0, 3'd2, 16'h0000);
        code_mem[13] = encode(XOR,  3'd4, 3'd0, 3'd0, 16'h0000);
        code_mem[14] = encode(SUB,  3'd5, 3'd0, 3'd1, 16'h0000);
        for (int i = 0; i < RANDOM_LEN; i++) begin
            inst = $urandom();
            inst[31] = 1'b0;                    // defined opcodes only.
            code_mem[DIRECTED_LEN + i] = inst;
        end
        code_mem[PROG_LEN - 1] = 32'hbe00_1234; // opcode 4'hb is undefined.
    endtask

    // sequential execution of the program, one expected commit per retiring op.
    task automatic run_model();
        word_t       regs [8];
        word_t       inst;
        word_t       res;
        logic [3:0]  opc;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [15:0] imm;
        logic        retires;
        for (int r = 0; r < 8; r++)
            regs[r] = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            inst    = code_mem[i];
            opc     = inst[31:28];
            rd      = inst[27:25];
            rs1     = inst[24:22];
            rs2     = inst[21:19];
            imm     = inst[15:0];
            retires = 1'b1;
            res     = '0;
            case (opc)
                ADD:     res = regs[rs1] + regs[rs2];
                SUB:     res = regs[rs1] - regs[rs2];
                AND:     res = regs[rs1] & regs[rs2];
                OR:      res = regs[rs1] | regs[rs2];
                XOR:     res = regs[rs1] ^ regs[rs2];
                ADDI:    res = regs[rs1] + {{16{imm[15]}}, imm};
                LUI:     res = {imm, 16'h0000};
                default: retires = 1'b0;        // NOP and undefined codes.
            endcase
            if (retires) begin
                exp_rd.push_back(rd);
                exp_data.push_back(res);
                if (rd != 3'd0)
                    regs[rd] = res;             // r0 stays zero.
            end
            if (i == DIRECTED_LEN - 1)
                directed_commits = exp_rd.size();
        end
    endtask

    task automatic check_reset_state();
        assert (code_addr == '0) else
            stop_with_error($sformatf("** Error: code_addr expected 0x0 got 0x%h", code_addr));
        assert (!commit_valid) else
            stop_with_error("** Error: commit_valid expected 0x0 got 0x1");
        assert (!illegal) else
            stop_with_error("** Error: illegal expected 0x0 got 0x1");
    endtask

    // called at each falling edge, a transfer happens at the next rising edge.
    task automatic check_cycle();
        reg_addr_t want_rd;
        word_t     want_data;
        if (stall_seen)
            assert (code_addr == stall_addr) else
                stop_with_error($sformatf("** Error: code_addr expected 0x%h got 0x%h",
                                          stall_addr, code_addr));
        if (commits_seen < directed_commits)
            assert (!illegal) else
                stop_with_error("** Error: illegal expected 0x0 got 0x1");
        if (commit_valid && first_edge < 0) begin
            first_edge = edges;
            assert (edges == 3) else
                stop_with_error($sformatf("first commit came %0d edges after reset, not 3",
                                          edges));
        end
        if (commit_valid && commit_ready) begin
            if (commits_seen > 0 && commits_seen < CHAIN_LEN)
                assert (edges == last_edge + 1) else
                    stop_with_error("dependent chain did not commit on back-to-back cycles");
            want_rd   = exp_rd.pop_front();
            want_data = exp_data.pop_front();
            assert (commit_rd == want_rd) else
                stop_with_error($sformatf("** Error: commit_rd expected 0x%h got 0x%h",
                                          want_rd, commit_rd));
            assert (commit_data == want_data) else
                stop_with_error($sformatf("** Error: commit_data expected 0x%h got 0x%h",
                                          want_data, commit_data));
            commits_seen++;
            last_edge = edges;
        end
        stall_seen = commit_valid && !commit_ready;
        stall_addr = code_addr;
    endtask

    // sink back-pressure, full rate for the directed part.
    always @(posedge clk) begin
        #1;
        if (commits_seen < directed_commits)
            commit_ready <= 1'b1;
        else
            commit_ready <= ($urandom() % 100) < 70;
    end

    initial begin : watchdog
        wait (prog_ready);
        repeat (WATCHDOG) @(posedge clk);
        stop_with_error("timeout, commits stopped arriving before the program retired");
    end

    initial begin : main
        commit_ready     = 1'b1;
        prog_ready       = 1'b0;
        directed_commits = 0;
        commits_seen     = 0;
        edges            = 0;
        first_edge       = -1;
        last_edge        = 0;
        stall_seen       = 1'b0;
        stall_addr       = '0;
        void'($urandom(SEED));
        load_program();
        run_model();
        prog_ready = 1'b1;

        @(posedge rst_n);
        @(negedge clk);
        check_reset_state();

        while (exp_rd.size() > 0) begin
            @(negedge clk);
            edges++;
            check_cycle();
        end

        // only the undefined op and NOP fill remain in flight.
        while (!illegal) begin
            @(negedge clk);
            assert (!commit_valid) else
                stop_with_error("** Error: commit_valid expected 0x0 got 0x1");
        end
        repeat (8) begin
            @(negedge clk);
            assert (illegal) else
                stop_with_error("** Error: illegal expected 0x1 got 0x0");
            assert (!commit_valid) else
                stop_with_error("** Error: commit_valid expected 0x0 got 0x1");
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released just after an edge, so no flop sees it change.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog/core_top.sv
// three-stage core top level
`timescale 1ns/1ns
`default_nettype none

module core_top
    import core_pkg::*;
#(
    parameter int CODE_AW = CODE_AW_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic [CODE_AW-1:0] code_addr,
    input  word_t              code_data,
    output logic               commit_valid,
    output reg_addr_t          commit_rd,
    output word_t              commit_data,
    input  logic               commit_ready,
    output logic               illegal
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      fwd_valid;                    // execute result bypass.
    reg_addr_t fwd_rd;
    word_t     fwd_data;
    logic      we;                           // write-back port.
    reg_addr_t wr_addr;
    word_t     wr_data;

    stage_if #(.T(id_t)) id_if ();           // fetch to decode.
    stage_if #(.T(ex_t)) ex_if ();           // decode to execute.

    fetch #(
        .CODE_AW(CODE_AW)
    ) fetch_inst (
        .clk,
        .rst_n,
        .code_addr,
        .code_data,
        .down(id_if)
    );

    regfile regfile_inst (
        .clk,
        .rd1_addr(rs1_addr),
        .rd2_addr(rs2_addr),
        .rd1_data(rs1_data),
        .rd2_data(rs2_data),
        .we,
        .wr_addr,
        .wr_data
    );

    decode decode_inst (
        .clk,
        .rst_n,
        .up(id_if),
        .down(ex_if),
        .rs1_addr,
        .rs2_addr,
        .rs1_data,
        .rs2_data,
        .fwd_valid,
        .fwd_rd,
        .fwd_data,
        .illegal
    );

    execute execute_inst (
        .clk,
        .rst_n,
        .up(ex_if),
        .commit_valid,
        .commit_rd,
        .commit_data,
        .commit_ready,
        .fwd_valid,
        .fwd_rd,
        .fwd_data,
        .we,
        .wr_addr,
        .wr_data
    );

endmodule

`default_nettype wire

// File: verilog/execute.sv
// execute stage
`timescale 1ns/1ns
`default_nettype none

module execute
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    stage_if.down     up,
    output logic      commit_valid,
    output reg_addr_t commit_rd,
    output word_t     commit_data,
    input  logic      commit_ready,
    output logic      fwd_valid,
    output reg_addr_t fwd_rd,
    output word_t     fwd_data,
    output logic      we,
    output reg_addr_t wr_addr,
    output word_t     wr_data
);

    word_t     alu;
    logic      valid_q;
    op_t       op_q;
    reg_addr_t rd_q;
    word_t     res_q;
    logic      live;                         // held item wants to retire.

    always_comb begin
        case (up.data.op)
            ADD, ADDI, LUI: alu = up.data.a + up.data.b;
            SUB:            alu = up.data.a - up.data.b;
            AND:            alu = up.data.a & up.data.b;
            OR:             alu = up.data.a | up.data.b;
            XOR:            alu = up.data.a ^ up.data.b;
            default:        alu = '0;        // NOP.
        endcase
    end

    assign live = valid_q && op_q != NOP;

    // empty, a NOP being dropped, or a commit this edge.
    assign up.ready = !live || commit_ready;

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else if (up.ready)
            valid_q <= up.valid;
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.ready) begin
            op_q  <= up.data.op;
            rd_q  <= up.data.rd;
            res_q <= alu;
        end
    end

    assign commit_valid = live;
    assign commit_rd    = rd_q;
    assign commit_data  = res_q;

    assign fwd_valid = live;                 // not yet in the register file.
    assign fwd_rd    = rd_q;
    assign fwd_data  = res_q;

    assign we      = live && commit_ready;   // written on the commit transfer.
    assign wr_addr = rd_q;
    assign wr_data = res_q;

endmodule

`default_nettype wire

// File: verilog/decode.sv
// decode stage
`timescale 1ns/1ns
`default_nettype none

module decode
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    stage_if.down     up,
    stage_if.up       down,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  logic      fwd_valid,
    input  reg_addr_t fwd_rd,
    input  word_t     fwd_data,
    output logic      illegal
);

    word_t      inst;
    logic [3:0] opc;
    imm_t       imm;
    logic       accept;

    op_t        op_d;                        // opcode after the legality check.
    logic       bad_d;
    logic       use_imm_d;
    logic       zero_a_d;
    word_t      imm_d;                       // immediate already shaped for b.

    logic       valid_q;
    op_t        op_q;
    reg_addr_t  rd_q;
    reg_addr_t  rs1_q;
    reg_addr_t  rs2_q;
    word_t      imm_q;
    logic       use_imm_q;
    logic       zero_a_q;
    word_t      pc_q;

    word_t      src1;
    word_t      src2;
    word_t      a_sel;
    word_t      b_sel;

    assign inst   = up.data.inst;
    assign opc    = inst[OPC_HI:OPC_LO];
    assign imm    = inst[IMM_HI:IMM_LO];
    assign accept = up.valid && up.ready;

    always_comb begin
        op_d      = NOP;
        bad_d     = 1'b0;
        use_imm_d = 1'b0;
        zero_a_d  = 1'b0;
        imm_d     = '0;
        case (opc)
            NOP, ADD, SUB, AND, OR, XOR: op_d = op_t'(opc);
            ADDI: begin
                op_d      = ADDI;
                use_imm_d = 1'b1;
                imm_d     = {{16{imm[15]}}, imm};   // sign extended.
            end
            LUI: begin
                op_d      = LUI;
                use_imm_d = 1'b1;
                zero_a_d  = 1'b1;                   // result is 0 + b.
                imm_d     = {imm, 16'h0000};
            end
            default: bad_d = 1'b1;           // retires as a NOP.
        endcase
    end

    assign up.ready = !valid_q || down.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            illegal <= 1'b0;
        end else begin
            if (up.ready)
                valid_q <= up.valid;
            if (accept && bad_d)
                illegal <= 1'b1;             // sticky until reset.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= op_d;
            rd_q      <= inst[RD_HI:RD_LO];
            rs1_q     <= inst[RS1_HI:RS1_LO];
            rs2_q     <= inst[RS2_HI:RS2_LO];
            imm_q     <= imm_d;
            use_imm_q <= use_imm_d;
            zero_a_q  <= zero_a_d;
            pc_q      <= up.pc;
        end
    end

    // operands resolve from the held fields, so the older result in execute is seen.
    assign rs1_addr = rs1_q;
    assign rs2_addr = rs2_q;
    assign src1 = (fwd_valid && fwd_rd != '0 && fwd_rd == rs1_q) ? fwd_data : rs1_data;
    assign src2 = (fwd_valid && fwd_rd != '0 && fwd_rd == rs2_q) ? fwd_data : rs2_data;
    assign a_sel = zero_a_q ? '0 : src1;
    assign b_sel = use_imm_q ? imm_q : src2;

    assign down.valid = valid_q;
    assign down.data  = ex_t'{op_q, rd_q, a_sel, b_sel};
    assign down.pc    = pc_q;

endmodule

`default_nettype wire

// File: verilog/regfile.sv
// register file
`timescale 1ns/1ns
`default_nettype none

module regfile
    import core_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t rd1_addr,
    input  reg_addr_t rd2_addr,
    output word_t     rd1_data,
    output word_t     rd2_data,
    input  logic      we,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [8];                         // entry 0 is never written.

    always_ff @(posedge clk) begin
        if (we && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

    // write-first, a same-cycle write is seen by the read.
    assign rd1_data = (rd1_addr == '0)                 ? '0      :
                      (we && wr_addr == rd1_addr)      ? wr_data :
                                                         regs[rd1_addr];
    assign rd2_data = (rd2_addr == '0)                 ? '0      :
                      (we && wr_addr == rd2_addr)      ? wr_data :
                                                         regs[rd2_addr];

endmodule

`default_nettype wire

// File: verilog/fetch.sv
// fetch stage
`timescale 1ns/1ns
`default_nettype none

module fetch
    import core_pkg::*;
#(
    parameter int CODE_AW = CODE_AW_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic [CODE_AW-1:0] code_addr,
    input  word_t              code_data,
    stage_if.up                down
);

    logic [CODE_AW-1:0] pc;                  // next word to fetch.
    logic               valid_q;             // output register full.
    id_t                item_q;              // fetched word and its address.
    logic               load;

    // empty, or the held item leaves at this edge.
    assign load = !valid_q || down.ready;

    assign code_addr = pc;                   // stays put while stalled.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= '0;
            valid_q <= 1'b0;
        end else if (load) begin
            pc      <= pc + 1'b1;            // wraps at the end of code space.
            valid_q <= 1'b1;
        end
    end

    // code_data is valid in the same cycle as code_addr.
    always_ff @(posedge clk) begin
        if (load) begin
            item_q.pc   <= word_t'(pc);
            item_q.inst <= code_data;
        end
    end

    assign down.valid = valid_q;
    assign down.data  = item_q;
    assign down.pc    = item_q.pc;

endmodule

`default_nettype wire

// File: verilog/stage_if.sv
// stage stream
`timescale 1ns/1ns
`default_nettype none

interface stage_if
    import core_pkg::*;
#(
    parameter type T = word_t
) ();

    logic  valid;                            // sender has an item.
    logic  ready;                            // receiver can take it.
    T      data;                             // stage payload.
    word_t pc;                               // debug, address of the item.

    // sender side.
    modport up (
        output valid,
        output data,
        output pc,
        input  ready
    );

    // receiver side.
    modport down (
        input  valid,
        input  data,
        input  pc,
        output ready
    );

endinterface

`default_nettype wire

// File: verilog/core_pkg.sv
// three-stage core
// shared types and instruction layout
`default_nettype none

package core_pkg;

    localparam int CODE_AW_DEFAULT = 8;      // code port word address bits.

    typedef logic [31:0] word_t;             // data or instruction word.
    typedef logic [2:0]  reg_addr_t;         // one of eight registers.
    typedef logic [15:0] imm_t;              // raw immediate field.

    // codes 8 to 15 are undefined.
    typedef enum logic [3:0] {
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        AND  = 4'h3,
        OR   = 4'h4,
        XOR  = 4'h5,
        ADDI = 4'h6,
        LUI  = 4'h7
    } op_t;

    // instruction field positions.
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 28;
    localparam int RD_HI  = 27;
    localparam int RD_LO  = 25;
    localparam int RS1_HI = 24;
    localparam int RS1_LO = 22;
    localparam int RS2_HI = 21;
    localparam int RS2_LO = 19;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;

    typedef struct packed {
        word_t pc;                           // address of the word.
        word_t inst;                         // raw instruction.
    } id_t;

    typedef struct packed {
        op_t       op;                       // NOP for undefined codes too.
        reg_addr_t rd;                       // destination register.
        word_t     a;                        // first alu operand.
        word_t     b;                        // second operand or immediate.
    } ex_t;

endpackage

`default_nettype wire
